// File: kitchen_pkg.sv
package kitchen_pkg;

    // game flow, in the order the screens appear
    typedef enum logic [2:0] {
        WELCOME = 3'd0,
        START   = 3'd1,
        PLAY    = 3'd2,
        PAUSE   = 3'd3,
        FINISH  = 3'd4
    } game_state_t;

    typedef enum logic [2:0] {
        EDIT,
        WAIT_UP,
        WAIT_DOWN,
        WAIT_RIGHT,
        WAIT_LEFT,
        WAIT_DONE
    } name_state_t;

    typedef logic [7:0] letter_t;
    typedef logic [8:0] coord_t;
    typedef logic [1:0] dir_t;
    typedef logic [3:0] player_state_t;
    typedef logic [3:0] object_t;
    typedef logic [9:0] points_t;
    typedef logic [4:0] order_time_t;

    localparam letter_t LETTER_A = 8'h41;
    localparam letter_t LETTER_Z = 8'h5A;

    // object codes, fixed scenery from 8 up
    localparam object_t EMPTY          = 4'd0;
    localparam object_t TOMATO         = 4'd1;
    localparam object_t ONION          = 4'd2;
    localparam object_t CHOPPED_TOMATO = 4'd3;
    localparam object_t CHOPPED_ONION  = 4'd4;
    localparam object_t COUNTER        = 4'd8;
    localparam object_t CRATE_TOMATO   = 4'd9;
    localparam object_t CRATE_ONION    = 4'd10;

    localparam int NUM_PLAYERS       = 4;
    localparam int GRID_ROWS         = 8;
    localparam int GRID_COLS         = 13;
    localparam int TILE_SHIFT        = 5;
    localparam int START_FRAMES      = 180;
    localparam int FRAMES_PER_SECOND = 60;
    localparam int CHOP_FRAMES       = 15;
    localparam int MAX_ORDERS        = 4;
    localparam int ORDER_LIFE        = 20;
    localparam int NEW_ORDER_SECONDS = 8;
    localparam int ORDER_POINTS      = 20;

    // serving tiles sit on the right edge
    localparam int SERVE_ROW_A      = 3;
    localparam int SERVE_ROW_B      = 4;
    localparam int SERVE_COL        = 12;
    localparam int CRATE_TOMATO_COL = 2;
    localparam int CRATE_ONION_COL  = 10;

endpackage

// File: player_if.sv
`timescale 1ns/1ps

// one player's pose and requested action, as sent by the movement board
interface player_if;
    import kitchen_pkg::*;

    dir_t          direction;
    coord_t        x;
    coord_t        y;
    player_state_t state;

    modport source (output direction, x, y, state);
    modport sink   (input direction, x, y, state);

endinterface

// File: buttons_if.sv
`timescale 1ns/1ps

// local push buttons, sampled once per frame
interface buttons_if;
    logic left;
    logic right;
    logic up;
    logic down;
    logic chop;

    modport sink (input left, right, up, down, chop);

endinterface

// File: name_entry.sv
`timescale 1ns/1ps

module name_entry (
    input  logic                       vsync,
    input  logic                       reset,
    input  kitchen_pkg::game_state_t   game_state,
    buttons_if.sink                    buttons,
    output kitchen_pkg::letter_t [2:0] team_name,
    output logic                       name_done
);
    import kitchen_pkg::*;

    name_state_t n_state;
    logic [1:0]  cursor;
    letter_t     cur_letter;

    // first letter lives in the top slot
    assign cur_letter = team_name[2'd2 - cursor];

    always_ff @(posedge vsync) begin
        if (reset) begin
            team_name <= {LETTER_A, LETTER_A, LETTER_A};
            cursor    <= 2'd0;
            n_state   <= EDIT;
            name_done <= 1'b0;
        end else begin
            name_done <= 1'b0;
            if (game_state == WELCOME) begin
                case (n_state)
                    EDIT: begin
                        if (buttons.chop) begin
                            n_state <= WAIT_DONE;
                        end else if (buttons.up) begin
                            team_name[2'd2 - cursor] <= (cur_letter == LETTER_A) ?
                                                        LETTER_Z : cur_letter - 8'd1;
                            n_state <= WAIT_UP;
                        end else if (buttons.down) begin
                            team_name[2'd2 - cursor] <= (cur_letter == LETTER_Z) ?
                                                        LETTER_A : cur_letter + 8'd1;
                            n_state <= WAIT_DOWN;
                        end else if (buttons.right) begin
                            // right on the last letter finishes the name
                            n_state <= (cursor == 2'd2) ? WAIT_DONE : WAIT_RIGHT;
                        end else if (buttons.left && cursor != 2'd0) begin
                            n_state <= WAIT_LEFT;
                        end
                    end
                    WAIT_UP: begin
                        if (!buttons.up)
                            n_state <= EDIT;
                    end
                    WAIT_DOWN: begin
                        if (!buttons.down)
                            n_state <= EDIT;
                    end
                    // cursor moves on release
                    WAIT_RIGHT: begin
                        if (!buttons.right) begin
                            cursor  <= cursor + 2'd1;
                            n_state <= EDIT;
                        end
                    end
                    WAIT_LEFT: begin
                        if (!buttons.left) begin
                            cursor  <= cursor - 2'd1;
                            n_state <= EDIT;
                        end
                    end
                    WAIT_DONE: begin
                        if (!buttons.chop && !buttons.right) begin
                            name_done <= 1'b1;
                            cursor    <= 2'd0;
                            n_state   <= EDIT;
                        end
                    end
                    default: n_state <= EDIT;
                endcase
            end
        end
    end

    a_cursor_range: assert property (@(posedge vsync) disable iff (reset)
        cursor <= 2'd2);

    a_letter_range: assert property (@(posedge vsync) disable iff (reset)
        team_name[0] inside {[LETTER_A:LETTER_Z]} &&
        team_name[1] inside {[LETTER_A:LETTER_Z]} &&
        team_name[2] inside {[LETTER_A:LETTER_Z]});

endmodule

// File: game_flow.sv
`timescale 1ns/1ps

module game_flow (
    input  logic                     vsync,
    input  logic                     reset,
    input  logic                     name_done,
    buttons_if.sink                  buttons,
    input  logic                     pause,
    input  logic [7:0]               time_left,
    output kitchen_pkg::game_state_t game_state
);
    import kitchen_pkg::*;

    localparam int CNT_W = $clog2(START_FRAMES + 1);

    logic [CNT_W-1:0] start_count;
    logic             any_button;

    assign any_button = buttons.left | buttons.right | buttons.up | buttons.down | buttons.chop;

    always_ff @(posedge vsync) begin
        if (reset) begin
            game_state  <= WELCOME;
            start_count <= '0;
        end else begin
            case (game_state)
                WELCOME: begin
                    start_count <= '0;
                    if (name_done)
                        game_state <= START;
                end
                // map preview, players held still
                START: begin
                    if (start_count == CNT_W'(START_FRAMES)) begin
                        game_state  <= PLAY;
                        start_count <= '0;
                    end else begin
                        start_count <= start_count + 1'b1;
                    end
                end
                PLAY: begin
                    // running out of time beats a pause
                    if (time_left == 8'd0)
                        game_state <= FINISH;
                    else if (pause)
                        game_state <= PAUSE;
                end
                PAUSE: begin
                    if (!pause)
                        game_state <= PLAY;
                end
                FINISH: begin
                    if (any_button)
                        game_state <= WELCOME;
                end
                default: game_state <= WELCOME;
            endcase
        end
    end

    a_start_exit: assert property (@(posedge vsync) disable iff (reset)
        game_state == START |=> game_state inside {START, PLAY});

endmodule

// File: kitchen_action.sv
`timescale 1ns/1ps

module kitchen_action (
    input  logic                     vsync,
    input  logic                     reset,
    input  kitchen_pkg::game_state_t game_state,
    player_if.sink                   players [kitchen_pkg::NUM_PLAYERS],
    input  logic [1:0]               clear_space,
    output kitchen_pkg::object_t [kitchen_pkg::GRID_ROWS-1:0][kitchen_pkg::GRID_COLS-1:0]
                                     object_grid,
    output logic [kitchen_pkg::NUM_PLAYERS-1:0][3:0] time_grid
);
    import kitchen_pkg::*;

    localparam logic [3:0]    LAST_ROW = 4'(GRID_ROWS - 1);
    localparam logic [3:0]    LAST_COL = 4'(GRID_COLS - 1);
    localparam player_state_t CHOP_REQ = 4'hF;

    logic [3:0]    tgt_row [NUM_PLAYERS];
    logic [3:0]    tgt_col [NUM_PLAYERS];
    object_t       tgt_obj [NUM_PLAYERS];
    player_state_t req     [NUM_PLAYERS];

    // counters along the top, crates at two spots
    function automatic object_t init_tile(input int row, input int col);
        if (row != 0)
            return EMPTY;
        if (col == CRATE_TOMATO_COL)
            return CRATE_TOMATO;
        if (col == CRATE_ONION_COL)
            return CRATE_ONION;
        return COUNTER;
    endfunction

    for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_target
        logic [3:0] row;
        logic [3:0] col;

        // tile under the player, then one step the way it faces
        always_comb begin
            row = 4'(players[i].y >> TILE_SHIFT);
            col = 4'(players[i].x >> TILE_SHIFT);
            if (row > LAST_ROW)
                row = LAST_ROW;
            if (col > LAST_COL)
                col = LAST_COL;
            case (players[i].direction)
                2'd0:    if (row != 4'd0) row = row - 4'd1;
                2'd1:    if (col != LAST_COL) col = col + 4'd1;
                2'd2:    if (row != LAST_ROW) row = row + 4'd1;
                default: if (col != 4'd0) col = col - 4'd1;
            endcase
        end

        assign tgt_row[i] = row;
        assign tgt_col[i] = col;
        assign tgt_obj[i] = object_grid[row][col];
        assign req[i]     = players[i].state;

        a_chop_bound: assert property (@(posedge vsync) disable iff (reset)
            time_grid[i] < 4'(CHOP_FRAMES));
    end

    always_ff @(posedge vsync) begin
        if (reset || game_state == START) begin
            for (int r = 0; r < GRID_ROWS; r++) begin
                for (int c = 0; c < GRID_COLS; c++) begin
                    object_grid[r][c] <= init_tile(r, c);
                end
            end
            time_grid <= '0;
        end else if (game_state == PLAY) begin
            // served food leaves the counter
            if (clear_space[0])
                object_grid[SERVE_ROW_A][SERVE_COL] <= EMPTY;
            if (clear_space[1])
                object_grid[SERVE_ROW_B][SERVE_COL] <= EMPTY;

            // highest player first, so player 1 is written last and wins
            for (int p = NUM_PLAYERS - 1; p >= 0; p--) begin
                if (req[p] == CHOP_REQ && (tgt_obj[p] == TOMATO || tgt_obj[p] == ONION)) begin
                    if (time_grid[p] == 4'(CHOP_FRAMES - 1)) begin
                        object_grid[tgt_row[p]][tgt_col[p]] <= (tgt_obj[p] == TOMATO) ?
                                                               CHOPPED_TOMATO : CHOPPED_ONION;
                        time_grid[p] <= 4'd0;
                    end else begin
                        time_grid[p] <= time_grid[p] + 4'd1;
                    end
                end else begin
                    time_grid[p] <= 4'd0;
                    // place: low bits carry the held object
                    if (req[p][3] && req[p] != CHOP_REQ && req[p][2:0] != 3'd0 &&
                        tgt_obj[p] == EMPTY)
                        object_grid[tgt_row[p]][tgt_col[p]] <= {1'b0, req[p][2:0]};
                end
            end
        end
    end

endmodule

// File: orders_and_points.sv
`timescale 1ns/1ps

module orders_and_points (
    input  logic                         vsync,
    input  logic                         reset,
    input  logic                         timer_go,
    input  kitchen_pkg::game_state_t     game_state,
    input  kitchen_pkg::object_t [1:0]   check_spaces,
    output logic [1:0]                   clear_space,
    output kitchen_pkg::points_t         point_total,
    output logic [3:0]                   orders,
    output kitchen_pkg::order_time_t [kitchen_pkg::MAX_ORDERS-1:0] order_times
);
    import kitchen_pkg::*;

    localparam int      FRAME_W    = $clog2(FRAMES_PER_SECOND);
    localparam int      SPAWN_W    = $clog2(NEW_ORDER_SECONDS);
    localparam points_t POINTS_MAX = '1;
    localparam points_t POINTS_ADD = points_t'(ORDER_POINTS);

    logic [FRAME_W-1:0] frame_count;
    logic [SPAWN_W-1:0] sec_count;
    logic               second_tick;
    logic               spawn_tick;
    logic [1:0]         serve;
    logic [3:0]         next_orders;
    order_time_t [MAX_ORDERS-1:0] next_times;

    function automatic logic is_chopped(input object_t obj);
        return obj == CHOPPED_TOMATO || obj == CHOPPED_ONION;
    endfunction

    assign second_tick = timer_go && frame_count == FRAME_W'(FRAMES_PER_SECOND - 1);
    assign spawn_tick  = second_tick && sec_count == SPAWN_W'(NEW_ORDER_SECONDS - 1);

    // a tile still being cleared must not score twice; A goes first
    assign serve[0] = orders != 4'd0 && is_chopped(check_spaces[0]) && !clear_space[0];
    assign serve[1] = orders != 4'd0 && is_chopped(check_spaces[1]) && !clear_space[1] &&
                      !serve[0];

    always_comb begin
        next_times  = order_times;
        next_orders = orders;
        // serving always takes the oldest order
        if (serve != 2'b00) begin
            next_times  = {order_time_t'(0), next_times[MAX_ORDERS-1:1]};
            next_orders = next_orders - 4'd1;
        end
        if (second_tick) begin
            for (int k = 0; k < MAX_ORDERS; k++) begin
                if (4'(k) < next_orders)
                    next_times[k] = next_times[k] - 5'd1;
            end
            // oldest has the least time, so only slot 0 can run out
            if (next_orders != 4'd0 && next_times[0] == 5'd0) begin
                next_times  = {order_time_t'(0), next_times[MAX_ORDERS-1:1]};
                next_orders = next_orders - 4'd1;
            end
            if (spawn_tick && next_orders < 4'(MAX_ORDERS)) begin
                next_times[next_orders[1:0]] = order_time_t'(ORDER_LIFE);
                next_orders = next_orders + 4'd1;
            end
        end
    end

    always_ff @(posedge vsync) begin
        if (reset || game_state == START) begin
            orders      <= '0;
            order_times <= '0;
            point_total <= '0;
            clear_space <= '0;
            frame_count <= '0;
            sec_count   <= '0;
        end else if (game_state == PLAY) begin
            orders      <= next_orders;
            order_times <= next_times;
            clear_space <= serve;
            if (serve != 2'b00)
                point_total <= (point_total > POINTS_MAX - POINTS_ADD) ?
                               POINTS_MAX : point_total + POINTS_ADD;
            if (timer_go)
                frame_count <= second_tick ? '0 : frame_count + 1'b1;
            if (second_tick)
                sec_count <= spawn_tick ? '0 : sec_count + 1'b1;
        end else begin
            clear_space <= '0;
        end
    end

    a_order_limit: assert property (@(posedge vsync) disable iff (reset)
        orders <= 4'(MAX_ORDERS));

endmodule

// File: main_fpga_control.sv
`timescale 1ns/1ps

module main_fpga_control (
    input  logic                           reset,
    input  logic                           vsync,
    input  logic                           pause,
    input  logic                           left,
    input  logic                           right,
    input  logic                           up,
    input  logic                           down,
    input  logic                           chop,
    input  logic                           timer_go,
    input  logic [7:0]                     time_left,
    input  kitchen_pkg::dir_t              player1_direction,
    input  kitchen_pkg::dir_t              player2_direction,
    input  kitchen_pkg::dir_t              player3_direction,
    input  kitchen_pkg::dir_t              player4_direction,
    input  kitchen_pkg::coord_t            player1_x,
    input  kitchen_pkg::coord_t            player2_x,
    input  kitchen_pkg::coord_t            player3_x,
    input  kitchen_pkg::coord_t            player4_x,
    input  kitchen_pkg::coord_t            player1_y,
    input  kitchen_pkg::coord_t            player2_y,
    input  kitchen_pkg::coord_t            player3_y,
    input  kitchen_pkg::coord_t            player4_y,
    input  kitchen_pkg::player_state_t     player1_state,
    input  kitchen_pkg::player_state_t     player2_state,
    input  kitchen_pkg::player_state_t     player3_state,
    input  kitchen_pkg::player_state_t     player4_state,
    output kitchen_pkg::letter_t [2:0]     team_name,
    output kitchen_pkg::game_state_t       game_state,
    output kitchen_pkg::points_t           point_total,
    output kitchen_pkg::object_t [kitchen_pkg::GRID_ROWS-1:0][kitchen_pkg::GRID_COLS-1:0]
                                           object_grid,
    output logic [kitchen_pkg::NUM_PLAYERS-1:0][3:0] time_grid,
    output logic [3:0]                     orders,
    output kitchen_pkg::order_time_t [kitchen_pkg::MAX_ORDERS-1:0] order_times
);
    import kitchen_pkg::*;

    logic           name_done;
    logic [1:0]     clear_space;
    object_t [1:0]  check_spaces;

    player_if  players [NUM_PLAYERS] ();
    buttons_if buttons ();

    assign buttons.left  = left;
    assign buttons.right = right;
    assign buttons.up    = up;
    assign buttons.down  = down;
    assign buttons.chop  = chop;

    assign players[0].direction = player1_direction;
    assign players[0].x         = player1_x;
    assign players[0].y         = player1_y;
    assign players[0].state     = player1_state;
    assign players[1].direction = player2_direction;
    assign players[1].x         = player2_x;
    assign players[1].y         = player2_y;
    assign players[1].state     = player2_state;
    assign players[2].direction = player3_direction;
    assign players[2].x         = player3_x;
    assign players[2].y         = player3_y;
    assign players[2].state     = player3_state;
    assign players[3].direction = player4_direction;
    assign players[3].x         = player4_x;
    assign players[3].y         = player4_y;
    assign players[3].state     = player4_state;

    // the two serving tiles feed the order checker
    assign check_spaces[0] = object_grid[SERVE_ROW_A][SERVE_COL];
    assign check_spaces[1] = object_grid[SERVE_ROW_B][SERVE_COL];

    name_entry u_name_entry (
        .vsync(vsync), .reset(reset), .game_state(game_state), .buttons(buttons),
        .team_name(team_name), .name_done(name_done)
    );

    game_flow u_game_flow (
        .vsync(vsync), .reset(reset), .name_done(name_done), .buttons(buttons),
        .pause(pause), .time_left(time_left), .game_state(game_state)
    );

    kitchen_action u_kitchen_action (
        .vsync(vsync), .reset(reset), .game_state(game_state), .players(players),
        .clear_space(clear_space), .object_grid(object_grid), .time_grid(time_grid)
    );

    orders_and_points u_orders_and_points (
        .vsync(vsync), .reset(reset), .timer_go(timer_go), .game_state(game_state),
        .check_spaces(check_spaces), .clear_space(clear_space), .point_total(point_total),
        .orders(orders), .order_times(order_times)
    );

endmodule

// File: tb_main_fpga_control.sv
`timescale 1ns/1ps

module tb_main_fpga_control;
    import kitchen_pkg::*;

    // button bits as {left, right, up, down, chop}
    localparam logic [4:0] B_NONE  = 5'b00000;
    localparam logic [4:0] B_CHOP  = 5'b00001;
    localparam logic [4:0] B_DOWN  = 5'b00010;
    localparam logic [4:0] B_UP    = 5'b00100;
    localparam logic [4:0] B_RIGHT = 5'b01000;
    localparam logic [4:0] B_LEFT  = 5'b10000;

    // poses packed as {direction, x, y, state} with state left at 0 for or-ing in
    localparam logic [23:0] PARKED   = {2'd0, 9'd208, 9'd240, 4'd0};
    localparam logic [23:0] AT_BOARD = {2'd0, 9'd176, 9'd80, 4'd0};
    localparam logic [23:0] AT_SERVE = {2'd1, 9'd368, 9'd112, 4'd0};

    typedef struct packed {
        logic [2:0]       test;
        logic [15:0]      frames;
        logic             wait_state;
        logic [4:0]       btn;
        logic             pause;
        logic             timer_go;
        logic [7:0]       time_left;
        logic [3:0][23:0] plr;
        logic [2:0]       state;
        logic [23:0]      name;
        logic [9:0]       points;
        logic [3:0]       orders;
        logic [4:0]       time0;
        logic [3:0]       prow;
        logic [3:0]       pcol;
        logic [3:0]       obj;
        logic [3:0]       chop_cnt;
    } step_t;

    logic reset, vsync, pause, left, right, up, down, chop, timer_go;
    logic [7:0] time_left;
    dir_t player1_direction, player2_direction, player3_direction, player4_direction;
    coord_t player1_x, player2_x, player3_x, player4_x;
    coord_t player1_y, player2_y, player3_y, player4_y;
    player_state_t player1_state, player2_state, player3_state, player4_state;

    letter_t [2:0] team_name;
    game_state_t game_state;
    points_t point_total;
    object_t [GRID_ROWS-1:0][GRID_COLS-1:0] object_grid;
    logic [NUM_PLAYERS-1:0][3:0] time_grid;
    logic [3:0] orders;
    order_time_t [MAX_ORDERS-1:0] order_times;

    step_t tbl [0:63];
    string titles [1:6];
    int    n_rows = 0;
    int    checks = 0;
    int    errors = 0;
    int    test_errors = 0;
    bit    timed_out = 1'b0;

    main_fpga_control UUT (.*);

    initial begin
        vsync = 1'b0;
        forever #2 vsync = ~vsync;
    end

    task automatic add_stimulus(input int test, input int frames, input bit wait_state,
                                input logic [4:0] btn, input logic hold_pause,
                                input logic tgo, input logic [7:0] tleft,
                                input logic [23:0] p1);
        tbl[n_rows].test       = 3'(test);
        tbl[n_rows].frames     = 16'(frames);
        tbl[n_rows].wait_state = wait_state;
        tbl[n_rows].btn        = btn;
        tbl[n_rows].pause      = hold_pause;
        tbl[n_rows].timer_go   = tgo;
        tbl[n_rows].time_left  = tleft;
        tbl[n_rows].plr[0]     = p1;
        // other cooks idle along the bottom row
        for (int k = 1; k < NUM_PLAYERS; k++)
            tbl[n_rows].plr[k] = {2'd0, 9'(16 + 32 * k), 9'd240, 4'd0};
    endtask

    task automatic set_expected(input game_state_t st, input logic [23:0] name,
                                input int pts, input int ord, input int t0,
                                input int prow, input int pcol, input object_t obj,
                                input int chop_cnt);
        tbl[n_rows].state    = st;
        tbl[n_rows].name     = name;
        tbl[n_rows].points   = 10'(pts);
        tbl[n_rows].orders   = 4'(ord);
        tbl[n_rows].time0    = 5'(t0);
        tbl[n_rows].prow     = 4'(prow);
        tbl[n_rows].pcol     = 4'(pcol);
        tbl[n_rows].obj      = obj;
        tbl[n_rows].chop_cnt = 4'(chop_cnt);
        n_rows++;
    endtask

    task automatic build_table();
        titles[1] = "reset values";
        titles[2] = "name entry";
        titles[3] = "start preview";
        titles[4] = "chop and pause";
        titles[5] = "orders and serving";
        titles[6] = "finish and restart";

        add_stimulus(1, 1, 0, B_NONE, 0, 0, 100, PARKED);
        set_expected(WELCOME, "AAA", 0, 0, 0, 0, 2, CRATE_TOMATO, 0);
        add_stimulus(1, 1, 0, B_NONE, 0, 0, 100, PARKED);
        set_expected(WELCOME, "AAA", 0, 0, 0, 0, 10, CRATE_ONION, 0);
        add_stimulus(1, 1, 0, B_NONE, 0, 0, 100, PARKED);
        set_expected(WELCOME, "AAA", 0, 0, 0, 0, 0, COUNTER, 0);

        // each later row spends its first frame on the previous release
        add_stimulus(2, 4, 0, B_UP, 0, 0, 100, PARKED);
        set_expected(WELCOME, "ZAA", 0, 0, 0, 3, 12, EMPTY, 0);
        add_stimulus(2, 2, 0, B_DOWN, 0, 0, 100, PARKED);
        set_expected(WELCOME, "AAA", 0, 0, 0, 3, 12, EMPTY, 0);
        add_stimulus(2, 2, 0, B_RIGHT, 0, 0, 100, PARKED);
        set_expected(WELCOME, "AAA", 0, 0, 0, 1, 5, EMPTY, 0);
        add_stimulus(2, 2, 0, B_DOWN, 0, 0, 100, PARKED);
        set_expected(WELCOME, "ABA", 0, 0, 0, 1, 5, EMPTY, 0);
        add_stimulus(2, 2, 0, B_LEFT, 0, 0, 100, PARKED);
        set_expected(WELCOME, "ABA", 0, 0, 0, 1, 5, EMPTY, 0);
        add_stimulus(2, 2, 0, B_DOWN, 0, 0, 100, PARKED);
        set_expected(WELCOME, "BBA", 0, 0, 0, 1, 5, EMPTY, 0);
        add_stimulus(2, 3, 0, B_CHOP, 0, 0, 100, PARKED);
        set_expected(WELCOME, "BBA", 0, 0, 0, 1, 5, EMPTY, 0);
        add_stimulus(2, 10, 1, B_NONE, 0, 0, 100, PARKED);
        set_expected(START, "BBA", 0, 0, 0, 1, 5, EMPTY, 0);

        // one preview frame already went by after the wait row
        add_stimulus(3, 100, 0, B_NONE, 0, 0, 100, AT_BOARD | 24'd9);
        set_expected(START, "BBA", 0, 0, 0, 1, 5, EMPTY, 0);
        add_stimulus(3, 79, 0, B_NONE, 0, 0, 100, AT_BOARD | 24'd15);
        set_expected(START, "BBA", 0, 0, 0, 1, 5, EMPTY, 0);
        add_stimulus(3, 1, 0, B_NONE, 0, 0, 100, PARKED);
        set_expected(PLAY, "BBA", 0, 0, 0, 1, 5, EMPTY, 0);

        add_stimulus(4, 1, 0, B_NONE, 0, 0, 100, AT_BOARD | 24'd9);
        set_expected(PLAY, "BBA", 0, 0, 0, 1, 5, TOMATO, 0);
        add_stimulus(4, 5, 0, B_NONE, 0, 0, 100, AT_BOARD | 24'd15);
        set_expected(PLAY, "BBA", 0, 0, 0, 1, 5, TOMATO, 5);
        add_stimulus(4, 11, 0, B_NONE, 1, 0, 100, AT_BOARD | 24'd15);
        set_expected(PAUSE, "BBA", 0, 0, 0, 1, 5, TOMATO, 6);
        add_stimulus(4, 1, 0, B_NONE, 0, 0, 100, AT_BOARD | 24'd15);
        set_expected(PLAY, "BBA", 0, 0, 0, 1, 5, TOMATO, 6);
        add_stimulus(4, 8, 0, B_NONE, 0, 0, 100, AT_BOARD | 24'd15);
        set_expected(PLAY, "BBA", 0, 0, 0, 1, 5, TOMATO, 14);
        add_stimulus(4, 1, 0, B_NONE, 0, 0, 100, AT_BOARD | 24'd15);
        set_expected(PLAY, "BBA", 0, 0, 0, 1, 5, CHOPPED_TOMATO, 0);

        // first order lands on the 480th counted frame
        add_stimulus(5, 479, 0, B_NONE, 0, 1, 100, PARKED);
        set_expected(PLAY, "BBA", 0, 0, 0, 1, 5, CHOPPED_TOMATO, 0);
        add_stimulus(5, 1, 0, B_NONE, 0, 1, 100, PARKED);
        set_expected(PLAY, "BBA", 0, 1, 20, 3, 12, EMPTY, 0);
        add_stimulus(5, 1, 0, B_NONE, 0, 1, 100, AT_SERVE | 24'd11);
        set_expected(PLAY, "BBA", 0, 1, 20, 3, 12, CHOPPED_TOMATO, 0);
        add_stimulus(5, 1, 0, B_NONE, 0, 1, 100, PARKED);
        set_expected(PLAY, "BBA", 20, 0, 0, 3, 12, CHOPPED_TOMATO, 0);
        add_stimulus(5, 1, 0, B_NONE, 0, 1, 100, PARKED);
        set_expected(PLAY, "BBA", 20, 0, 0, 3, 12, EMPTY, 0);
        add_stimulus(5, 476, 0, B_NONE, 0, 1, 100, PARKED);
        set_expected(PLAY, "BBA", 20, 0, 0, 3, 12, EMPTY, 0);
        add_stimulus(5, 1, 0, B_NONE, 0, 1, 100, PARKED);
        set_expected(PLAY, "BBA", 20, 1, 20, 3, 12, EMPTY, 0);
        // two more orders spawn on the way and the oldest runs out at second 20
        add_stimulus(5, 1199, 0, B_NONE, 0, 1, 100, PARKED);
        set_expected(PLAY, "BBA", 20, 3, 1, 3, 12, EMPTY, 0);
        add_stimulus(5, 1, 0, B_NONE, 0, 1, 100, PARKED);
        set_expected(PLAY, "BBA", 20, 2, 8, 3, 12, EMPTY, 0);

        add_stimulus(6, 1, 0, B_NONE, 1, 1, 0, PARKED);
        set_expected(FINISH, "BBA", 20, 2, 8, 1, 5, CHOPPED_TOMATO, 0);
        add_stimulus(6, 3, 0, B_NONE, 0, 0, 100, PARKED);
        set_expected(FINISH, "BBA", 20, 2, 8, 1, 5, CHOPPED_TOMATO, 0);
        // left on the first letter leaves the name alone
        add_stimulus(6, 5, 1, B_LEFT, 0, 0, 100, PARKED);
        set_expected(WELCOME, "BBA", 20, 2, 8, 1, 5, CHOPPED_TOMATO, 0);
        add_stimulus(6, 1, 0, B_CHOP, 0, 0, 100, PARKED);
        set_expected(WELCOME, "BBA", 20, 2, 8, 1, 5, CHOPPED_TOMATO, 0);
        add_stimulus(6, 10, 1, B_NONE, 0, 0, 100, PARKED);
        set_expected(START, "BBA", 20, 2, 8, 1, 5, CHOPPED_TOMATO, 0);
        add_stimulus(6, 1, 0, B_NONE, 0, 0, 100, PARKED);
        set_expected(START, "BBA", 0, 0, 0, 1, 5, EMPTY, 0);
    endtask

    task automatic drive_step(input int i);
        {left, right, up, down, chop} <= tbl[i].btn;
        pause     <= tbl[i].pause;
        timer_go  <= tbl[i].timer_go;
        time_left <= tbl[i].time_left;
        {player1_direction, player1_x, player1_y, player1_state} <= tbl[i].plr[0];
        {player2_direction, player2_x, player2_y, player2_state} <= tbl[i].plr[1];
        {player3_direction, player3_x, player3_y, player3_state} <= tbl[i].plr[2];
        {player4_direction, player4_x, player4_y, player4_state} <= tbl[i].plr[3];
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_step(input int i);
        check_value("game_state", 32'(game_state), 32'(tbl[i].state));
        check_value("team_name", 32'(team_name), 32'(tbl[i].name));
        check_value("point_total", 32'(point_total), 32'(tbl[i].points));
        check_value("orders", 32'(orders), 32'(tbl[i].orders));
        check_value("order_times[0]", 32'(order_times[0]), 32'(tbl[i].time0));
        check_value($sformatf("object_grid[%0d][%0d]", tbl[i].prow, tbl[i].pcol),
                    32'(object_grid[tbl[i].prow][tbl[i].pcol]), 32'(tbl[i].obj));
        check_value("time_grid[0]", 32'(time_grid[0]), 32'(tbl[i].chop_cnt));
    endtask

    initial begin
        int cnt;

        reset     = 1'b1;
        {left, right, up, down, chop} = B_NONE;
        pause     = 1'b0;
        timer_go  = 1'b0;
        time_left = 8'd100;
        {player1_direction, player1_x, player1_y, player1_state} = PARKED;
        {player2_direction, player2_x, player2_y, player2_state} = PARKED;
        {player3_direction, player3_x, player3_y, player3_state} = PARKED;
        {player4_direction, player4_x, player4_y, player4_state} = PARKED;
        build_table();

        repeat (16) @(posedge vsync);
        reset <= 1'b0;
        drive_step(0);

        for (int i = 0; i < n_rows && !timed_out; i++) begin
            if (tbl[i].wait_state) begin
                // frames doubles as the timeout for a state wait
                cnt = 0;
                @(negedge vsync);
                while (game_state != tbl[i].state && cnt < tbl[i].frames) begin
                    @(negedge vsync);
                    cnt++;
                end
                if (game_state != tbl[i].state) begin
                    $display("step %0d: timed out with game_state %0d after %0d frames, wanted %0d",
                             i, game_state, cnt, tbl[i].state);
                    timed_out = 1'b1;
                end else begin
                    check_step(i);
                    @(posedge vsync);
                    if (i + 1 < n_rows)
                        drive_step(i + 1);
                end
            end else begin
                // next row goes out on the edge that samples this one last
                repeat (tbl[i].frames) @(posedge vsync);
                if (i + 1 < n_rows)
                    drive_step(i + 1);
                @(negedge vsync);
                check_step(i);
            end
            if (!timed_out && (i + 1 == n_rows || tbl[i + 1].test != tbl[i].test)) begin
                $display("behavior %0d, %s: %0d mismatches", tbl[i].test,
                         titles[tbl[i].test], test_errors);
                test_errors = 0;
            end
        end

        $display("%0d checks, %0d mismatches", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: main_fpga_control.f
kitchen_pkg.sv
player_if.sv
buttons_if.sv
name_entry.sv
game_flow.sv
kitchen_action.sv
orders_and_points.sv
main_fpga_control.sv
tb_main_fpga_control.sv
